/* include/mio_defines.svh */
`ifndef MIO_DEFINES_SVH
`define MIO_DEFINES_SVH

//##################################################
// mio adapter widths
//##################################################

// address and data width
`define MIO_AW 32

// emesh packet: srcaddr + data + dstaddr + 8 ctrl bits, padded to 40
`define MIO_PW (2*`MIO_AW+40)

// mio fifo packet, one extra byte on top of emesh
`define MIO_MPW (`MIO_PW+8)

// zero pad used when widening tx packets
`define MIO_PAD (`MIO_MPW-`MIO_PW)

`endif

/* source/emesh_pkg.sv */
`include "mio_defines.svh"

package emesh_pkg;

   //##################################################
   // emesh packet format
   //##################################################

   // transfer size opcode, bytes = 1 << datamode
   typedef enum logic [1:0] {
      dm_byte   = 2'b00, // 1 byte
      dm_half   = 2'b01, // 2 bytes
      dm_word   = 2'b10, // 4 bytes
      dm_double = 2'b11  // 8 bytes
   } datamode_e;

   // field layout, msb first
   typedef struct packed {
      logic [`MIO_AW-1:0] srcaddr;  // return address on reads
      logic [`MIO_AW-1:0] data;     // low data word
      logic [`MIO_AW-1:0] dstaddr;  // target address
      logic [4:0]         ctrlmode; // routing and ordering hints
      datamode_e          datamode; // size
      logic               write;    // bit 0
   } emesh_pkt_t;

endpackage

/* source/mio_pkg.sv */
package mio_pkg;

   //##################################################
   // mio configuration
   //##################################################

   // static settings from the register file
   typedef struct packed {
      logic       amode;    // auto address streaming
      logic [7:0] datasize; // only the low nibble matters
      logic [4:0] ctrlmode; // forced ctrlmode in amode
   } mio_cfg_t;

   // per beat address step in bytes, max 8
   typedef logic [3:0] stride_t;

   // bytes per beat for one datamode
   function automatic stride_t stride_of(input logic [1:0] dm);
      stride_t s;
      s = stride_t'(4'd1 << dm); // 1, 2, 4 or 8
      return s;
   endfunction

endpackage

/* source/emesh_if.sv */
`timescale 1ns/1ps
`include "mio_defines.svh"

// one set of unpacked emesh fields
interface emesh_if;

   logic                  write;
   emesh_pkg::datamode_e  datamode;
   logic [4:0]            ctrlmode;
   logic [`MIO_AW-1:0]    dstaddr;
   logic [`MIO_AW-1:0]    srcaddr;
   logic [`MIO_AW-1:0]    data;

   // producer side
   modport src (
      output write, datamode, ctrlmode,
      output dstaddr, srcaddr, data
   );

   // consumer side
   modport dst (
      input write, datamode, ctrlmode,
      input dstaddr, srcaddr, data
   );

endinterface

/* source/mio_decode.sv */
`timescale 1ns/1ps
`include "mio_defines.svh"

module mio_decode (
   input  logic [`MIO_MPW-1:0]    rx_packet, // from rx fifo
   input  mio_pkg::mio_cfg_t      cfg,       // static config
   emesh_if.src                   fields,    // parsed packet fields
   output emesh_pkg::datamode_e   cfg_mode,  // datamode for amode
   output logic [`MIO_AW-1:0]     raw_data   // streaming payload
);

   //##################################################
   // packet parse
   //##################################################

   emesh_pkg::emesh_pkt_t pkt;

   // top byte of the mio packet is ignored
   assign pkt = emesh_pkg::emesh_pkt_t'(rx_packet[`MIO_PW-1:0]);

   assign fields.write    = pkt.write;
   assign fields.datamode = pkt.datamode;
   assign fields.ctrlmode = pkt.ctrlmode;
   assign fields.dstaddr  = pkt.dstaddr;
   assign fields.srcaddr  = pkt.srcaddr;
   assign fields.data     = pkt.data;

   // in amode the low word is the data, no header
   assign raw_data = rx_packet[`MIO_AW-1:0];

   //##################################################
   // datasize to datamode
   //##################################################

   always_comb begin
      case (cfg.datasize[3:0])
         4'd1:    cfg_mode = emesh_pkg::dm_byte;
         4'd2:    cfg_mode = emesh_pkg::dm_half;
         4'd4:    cfg_mode = emesh_pkg::dm_word;
         default: cfg_mode = emesh_pkg::dm_double; // anything odd -> 8 bytes
      endcase
   end

   // config comes from the register file at the top
   // an x in the size nibble would quietly turn into a double
   always_comb begin
      assert (!$isunknown(cfg.datasize[3:0]))
         else $error("mio_decode: datasize unknown, datasize=%h", cfg.datasize);
   end

endmodule

/* source/mio_execute.sv */
`timescale 1ns/1ps
`include "mio_defines.svh"

module mio_execute (
   input  logic                 clk,
   input  logic                 rst_n,
   input  mio_pkg::mio_cfg_t    cfg,        // amode, ctrlmode
   input  logic [`MIO_AW-1:0]   dstaddr,    // base address for amode
   input  logic                 accept,     // beat taken by the core
   input  emesh_pkg::datamode_e cfg_mode,   // from datasize
   input  logic [`MIO_AW-1:0]   raw_data,   // low word of rx packet
   emesh_if.dst                 in_fields,  // parsed packet
   emesh_if.src                 out_fields, // to packer
   output mio_pkg::stride_t     addrincr    // step for outside regs
);

   //##################################################
   // auto increment address
   //##################################################

   mio_pkg::stride_t    stride;
   logic                addr_update;
   logic [`MIO_AW-1:0]  addr_q;

   assign stride      = mio_pkg::stride_of(cfg_mode); // bytes per beat
   assign addr_update = cfg.amode & accept;           // step only on taken beats

   assign addrincr = addr_update ? stride : '0;

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         addr_q <= '0;
      end else if (!cfg.amode) begin
         addr_q <= dstaddr;                       // track base while idle
      end else if (accept) begin
         addr_q <= addr_q + `MIO_AW'(stride);     // next beat address
      end
   end

   //##################################################
   // field select
   //##################################################

   always_comb begin
      if (cfg.amode) begin
         out_fields.write    = 1'b1;          // streaming is write only
         out_fields.datamode = cfg_mode;
         out_fields.ctrlmode = cfg.ctrlmode;
         out_fields.dstaddr  = addr_q;
         out_fields.srcaddr  = '0;            // no return path
         out_fields.data     = raw_data;
      end else begin
         // normal mode, packet unchanged
         out_fields.write    = in_fields.write;
         out_fields.datamode = in_fields.datamode;
         out_fields.ctrlmode = in_fields.ctrlmode;
         out_fields.dstaddr  = in_fields.dstaddr;
         out_fields.srcaddr  = in_fields.srcaddr;
         out_fields.data     = in_fields.data;
      end
   end

   //##################################################
   // checks
   //##################################################

   // outside register file and local address step together
   a_incr_on_beat : assert property (
      @(posedge clk) disable iff (!rst_n)
      (addrincr != '0) |=> (addr_q == $past(addr_q) + `MIO_AW'($past(addrincr)))
   ) else $error("mio_execute: address did not step by addrincr");

   // stalled or idle stream keeps its address
   a_addr_hold : assert property (
      @(posedge clk)
      (rst_n && cfg.amode && !accept) |=> (addr_q == $past(addr_q))
   ) else $error("mio_execute: address moved without a beat");

endmodule

/* source/mio_result.sv */
`timescale 1ns/1ps
`include "mio_defines.svh"

module mio_result (
   emesh_if.dst                  fields,        // final fields
   output emesh_pkg::emesh_pkt_t packet_out,    // to core
   input  logic [`MIO_PW-1:0]    tx_packet_in,  // from core
   output logic [`MIO_MPW-1:0]   tx_packet_out  // to tx fifo
);

   //##################################################
   // rx, fields back into a packet
   //##################################################

   always_comb begin
      packet_out          = '0;
      packet_out.srcaddr  = fields.srcaddr;
      packet_out.data     = fields.data;
      packet_out.dstaddr  = fields.dstaddr;
      packet_out.ctrlmode = fields.ctrlmode;
      packet_out.datamode = fields.datamode;
      packet_out.write    = fields.write;
   end

   //##################################################
   // tx, widen to mio width
   //##################################################

   // extra top byte stays zero
   assign tx_packet_out = {{`MIO_PAD{1'b0}}, tx_packet_in};

endmodule

/* source/mio_if.sv */
`timescale 1ns/1ps
`include "mio_defines.svh"

module mio_if (
   // clock, reset, config
   input  logic                clk,
   input  logic                rst_n,
   input  logic                amode,         // auto address mode
   input  logic [7:0]          datasize,      // bytes per beat
   input  logic [4:0]          ctrlmode,      // ctrlmode for amode
   input  logic [`MIO_AW-1:0]  dstaddr,       // amode base address
   output logic [3:0]          addrincr,      // step for register file
   // core side
   output logic                access_out,
   output logic [`MIO_PW-1:0]  packet_out,    // rx packet for core
   input  logic                wait_in,
   input  logic                access_in,
   input  logic [`MIO_PW-1:0]  packet_in,     // tx packet from core
   output logic                wait_out,
   // fifo side
   input  logic                rx_access_in,
   input  logic [`MIO_MPW-1:0] rx_packet_in,
   output logic                rx_wait_out,
   output logic                tx_access_out,
   output logic [`MIO_MPW-1:0] tx_packet_out,
   input  logic                tx_wait_in
);

   mio_pkg::mio_cfg_t      cfg;
   mio_pkg::stride_t       incr;
   emesh_pkg::datamode_e   cfg_mode;
   emesh_pkg::emesh_pkt_t  pkt_out;
   logic [`MIO_AW-1:0]     raw_data;
   logic                   accept;

   emesh_if pkt_fields (); // decode -> execute
   emesh_if out_fields (); // execute -> result

   //##################################################
   // strobes
   //##################################################

   assign rx_wait_out   = wait_in;      // core back-pressure to rx fifo
   assign access_out    = rx_access_in;
   assign tx_access_out = access_in;
   assign wait_out      = tx_wait_in;   // tx fifo full to core

   assign accept = rx_access_in & ~wait_in; // beat taken this cycle

   assign cfg.amode    = amode;
   assign cfg.datasize = datasize;
   assign cfg.ctrlmode = ctrlmode;

   //##################################################
   // datapath
   //##################################################

   mio_decode u_decode (
      .rx_packet (rx_packet_in),
      .cfg       (cfg),
      .fields    (pkt_fields.src),
      .cfg_mode  (cfg_mode),
      .raw_data  (raw_data)
   );

   mio_execute u_execute (
      .clk        (clk),
      .rst_n      (rst_n),
      .cfg        (cfg),
      .dstaddr    (dstaddr),
      .accept     (accept),
      .cfg_mode   (cfg_mode),
      .raw_data   (raw_data),
      .in_fields  (pkt_fields.dst),
      .out_fields (out_fields.src),
      .addrincr   (incr)
   );

   mio_result u_result (
      .fields        (out_fields.dst),
      .packet_out    (pkt_out),
      .tx_packet_in  (packet_in),
      .tx_packet_out (tx_packet_out)
   );

   assign packet_out = pkt_out;
   assign addrincr   = incr;

endmodule

/* tb/tb_mio_if.sv */
`timescale 1ns/1ps
`include "mio_defines.svh"

module tb_mio_if;

   localparam int TIMEOUT_CYCLES = 2000; // tests need about 300

   logic                clk = 1'b0;
   logic                rst_n;
   logic                amode;
   logic [7:0]          datasize;
   logic [4:0]          ctrlmode;
   logic [`MIO_AW-1:0]  dstaddr;
   logic [3:0]          addrincr;
   logic                access_out;
   logic [`MIO_PW-1:0]  packet_out;
   logic                wait_in;
   logic                access_in;
   logic [`MIO_PW-1:0]  packet_in;
   logic                wait_out;
   logic                rx_access_in;
   logic [`MIO_MPW-1:0] rx_packet_in;
   logic                rx_wait_out;
   logic                tx_access_out;
   logic [`MIO_MPW-1:0] tx_packet_out;
   logic                tx_wait_in;

   int          errors = 0;
   int          cycles = 0;
   logic [31:0] seed_ret;

   mio_if DUT (
      .clk           (clk),
      .rst_n         (rst_n),
      .amode         (amode),
      .datasize      (datasize),
      .ctrlmode      (ctrlmode),
      .dstaddr       (dstaddr),
      .addrincr      (addrincr),
      .access_out    (access_out),
      .packet_out    (packet_out),
      .wait_in       (wait_in),
      .access_in     (access_in),
      .packet_in     (packet_in),
      .wait_out      (wait_out),
      .rx_access_in  (rx_access_in),
      .rx_packet_in  (rx_packet_in),
      .rx_wait_out   (rx_wait_out),
      .tx_access_out (tx_access_out),
      .tx_packet_out (tx_packet_out),
      .tx_wait_in    (tx_wait_in)
   );

   always #4 clk = ~clk; // 8 ns period

   // watchdog
   always @(posedge clk) begin
      cycles = cycles + 1;
      if (cycles >= TIMEOUT_CYCLES) begin
         $display("timed out after %0d cycles before the tests finished", cycles);
         $display("errors: %0d", errors);
         $display("Something failed");
         $finish;
      end
   end

   //##################################################
   // helpers
   //##################################################

   task automatic note_error(input string msg);
      errors = errors + 1;
      $display("** Error at %0t: %s", $time, msg);
   endtask

   task automatic next_cycle();
      @(posedge clk);
      #1; // drive point
   endtask

   function automatic logic rand_bit();
      logic [31:0] r;
      r = $urandom;
      return r[0];
   endfunction

   function automatic logic [4:0] rand_ctrl();
      logic [31:0] r;
      r = $urandom;
      return r[4:0];
   endfunction

   function automatic logic [`MIO_AW-1:0] rand_word();
      logic [127:0] r;
      r = {$urandom, $urandom, $urandom, $urandom};
      return r[`MIO_AW-1:0];
   endfunction

   function automatic logic [`MIO_PW-1:0] rand_pw();
      logic [127:0] r;
      r = {$urandom, $urandom, $urandom, $urandom};
      return r[`MIO_PW-1:0];
   endfunction

   function automatic logic [`MIO_MPW-1:0] rand_mpw();
      logic [127:0] r;
      r = {$urandom, $urandom, $urandom, $urandom};
      return r[`MIO_MPW-1:0];
   endfunction

   // datasize low nibble 1/2/4, everything else is a double
   function automatic emesh_pkg::datamode_e mode_for_size(input logic [7:0] size);
      case (size[3:0])
         4'd1:    return emesh_pkg::dm_byte;
         4'd2:    return emesh_pkg::dm_half;
         4'd4:    return emesh_pkg::dm_word;
         default: return emesh_pkg::dm_double;
      endcase
   endfunction

   function automatic logic [3:0] stride_for_size(input logic [7:0] size);
      case (size[3:0])
         4'd1:    return 4'd1;
         4'd2:    return 4'd2;
         4'd4:    return 4'd4;
         default: return 4'd8;
      endcase
   endfunction

   //##################################################
   // directed tests
   //##################################################

   // 16 edges with rst_n low, then the idle amode stream sits at 0
   // amode low first, so without reset the register would hold dstaddr
   task automatic check_reset();
      emesh_pkg::emesh_pkt_t got;
      amode   = 1'b0;
      dstaddr = rand_word(); // must not leak into the register
      for (int i = 0; i < 16; i++) begin
         next_cycle();
         if (i == 14) amode = 1'b1; // last reset edge sees amode high
         if (i == 15) rst_n = 1'b1; // 16th edge already sampled low
         #2;
         if (addrincr !== 4'd0)
            note_error($sformatf("addrincr %h during reset", addrincr));
      end
      repeat (3) begin
         next_cycle();
         #2;
         got = packet_out;
         if (addrincr !== 4'd0)
            note_error($sformatf("addrincr %h after reset", addrincr));
         if (got.dstaddr !== '0)
            note_error($sformatf("dstaddr %h after reset, expected 0", got.dstaddr));
      end
   endtask

   task automatic check_pass_through();
      amode = 1'b0;
      repeat (24) begin
         next_cycle();
         rx_access_in = rand_bit();
         wait_in      = rand_bit();
         access_in    = rand_bit();
         tx_wait_in   = rand_bit();
         #2;
         if (access_out !== rx_access_in)
            note_error("access_out does not follow rx_access_in");
         if (rx_wait_out !== wait_in)
            note_error("rx_wait_out does not follow wait_in");
         if (tx_access_out !== access_in)
            note_error("tx_access_out does not follow access_in");
         if (wait_out !== tx_wait_in)
            note_error("wait_out does not follow tx_wait_in");
      end
   endtask

   task automatic check_tx_widen();
      repeat (16) begin
         next_cycle();
         packet_in = rand_pw();
         #2;
         if (tx_packet_out[`MIO_PW-1:0] !== packet_in)
            note_error($sformatf("tx low bits %h, expected %h",
                                 tx_packet_out[`MIO_PW-1:0], packet_in));
         if (tx_packet_out[`MIO_MPW-1:`MIO_PW] !== '0)
            note_error($sformatf("tx pad byte %h, expected 0",
                                 tx_packet_out[`MIO_MPW-1:`MIO_PW]));
      end
   endtask

   // amode low, packet goes through untouched
   task automatic check_normal_rx();
      amode = 1'b0;
      repeat (24) begin
         next_cycle();
         rx_packet_in = rand_mpw();
         rx_access_in = rand_bit();
         wait_in      = rand_bit();
         dstaddr      = rand_word();
         #2;
         if (packet_out !== rx_packet_in[`MIO_PW-1:0])
            note_error($sformatf("packet_out %h, expected %h",
                                 packet_out, rx_packet_in[`MIO_PW-1:0]));
         if (addrincr !== 4'd0)
            note_error($sformatf("addrincr %h in normal mode", addrincr));
      end
   endtask

   task automatic check_amode_fields();
      logic [7:0]            sizes [4] = '{8'd1, 8'd2, 8'd4, 8'd7};
      emesh_pkg::emesh_pkt_t got;
      emesh_pkg::datamode_e  exp_mode;
      amode = 1'b1;
      foreach (sizes[k]) begin
         repeat (5) begin
            next_cycle();
            datasize     = sizes[k];
            ctrlmode     = rand_ctrl();
            rx_packet_in = rand_mpw();
            rx_access_in = rand_bit();
            wait_in      = rand_bit();
            #2;
            got      = packet_out;
            exp_mode = mode_for_size(datasize);
            if (got.write !== 1'b1)
               note_error("write not forced in amode");
            if (got.datamode !== exp_mode)
               note_error($sformatf("datamode %h for datasize %h, expected %h",
                                    got.datamode, datasize, exp_mode));
            if (got.ctrlmode !== ctrlmode)
               note_error($sformatf("ctrlmode %h, expected %h", got.ctrlmode, ctrlmode));
            if (got.srcaddr !== '0)
               note_error($sformatf("srcaddr %h, expected 0", got.srcaddr));
            if (got.data !== rx_packet_in[`MIO_AW-1:0])
               note_error($sformatf("data %h, expected %h",
                                    got.data, rx_packet_in[`MIO_AW-1:0]));
         end
      end
   endtask

   // base load, then a stalled stream over every stride
   task automatic check_addr_stream();
      logic [7:0]            sizes [4] = '{8'd1, 8'd2, 8'd4, 8'd8};
      emesh_pkg::emesh_pkt_t got;
      logic [`MIO_AW-1:0]    model;
      logic [3:0]            stride;
      logic [3:0]            exp_incr;
      logic                  acc;
      next_cycle();
      amode        = 1'b0;
      rx_access_in = 1'b0;
      wait_in      = 1'b0;
      dstaddr      = rand_word();
      model        = dstaddr; // loaded at the next edge
      foreach (sizes[k]) begin
         repeat (40) begin
            next_cycle();
            amode        = 1'b1;
            datasize     = sizes[k];
            rx_access_in = rand_bit() | rand_bit(); // mostly valid
            wait_in      = rand_bit();
            rx_packet_in = rand_mpw();
            dstaddr      = rand_word();             // ignored in amode
            #2;
            stride   = stride_for_size(datasize);
            acc      = rx_access_in & ~wait_in;
            exp_incr = acc ? stride : 4'd0;
            got      = packet_out;
            if (addrincr !== exp_incr)
               note_error($sformatf("addrincr %h, expected %h", addrincr, exp_incr));
            if (got.dstaddr !== model)
               note_error($sformatf("stream dstaddr %h, expected %h", got.dstaddr, model));
            if (acc) model = model + {{(`MIO_AW-4){1'b0}}, stride}; // step after edge
         end
      end
   endtask

   //##################################################
   // main
   //##################################################

   initial begin
      seed_ret     = $urandom(32'h592f8965);
      rst_n        = 1'b0;
      amode        = 1'b0;
      datasize     = 8'd4;
      ctrlmode     = 5'd0;
      dstaddr      = '0;
      wait_in      = 1'b0;
      access_in    = 1'b0;
      packet_in    = '0;
      rx_access_in = 1'b0;
      rx_packet_in = '0;
      tx_wait_in   = 1'b0;

      check_reset();
      check_pass_through();
      check_tx_widen();
      check_normal_rx();
      check_amode_fields();
      check_addr_stream();

      next_cycle();
      $display("errors: %0d after %0d cycles", errors, cycles);
      if (errors == 0) begin
         $display("Everything OK");
      end else begin
         $display("Something failed");
      end
      $finish;
   end

endmodule

/* flist.f */
+incdir+include
source/emesh_pkg.sv
source/mio_pkg.sv
source/emesh_if.sv
source/mio_decode.sv
source/mio_execute.sv
source/mio_result.sv
source/mio_if.sv
tb/tb_mio_if.sv

/* run_sim.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f flist.f --top-module tb_mio_if -o sim_mio

out=$(./obj_dir/sim_mio 2>&1) || true
echo "$out"

if echo "$out" | grep -q "Everything OK"; then
   exit 0
else
   exit 1
fi
